// File: icache.f
hdl/icache_pkg.sv
hdl/icache_tag_store.sv
hdl/icache_data_store.sv
hdl/icache_apb_refill.sv
hdl/icache_fetch_ctrl.sv
hdl/icache_top.sv
verification/icache_apb_mem.sv
verification/icache_tb.sv

// File: verification/icache_tb.sv
`default_nettype none

module icache_tb import icache_pkg::*; ();

	localparam logic [31:0] DATA_KEY = 32'h5eed_c0de;
	localparam int NUM_TESTS = 19;
	localparam int CYCLE_LIMIT = NUM_TESTS * 40;

	// flush_mode 0 none, 1 right after accept, 2 once the refill runs
	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  stall;
		logic [1:0]  flush_mode;
		logic [3:0]  xfers;
	} entry_t;

	logic clk;
	logic rst;
	logic flush;
	logic req_valid;
	icache_addr_u req_addr;
	logic req_ready;
	icache_rsp_t rsp;
	logic rsp_ready;
	logic psel;
	logic penable;
	logic [31:0] paddr;
	logic pwrite;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	entry_t tbl [NUM_TESTS];
	int cycle = 0;
	int error_count;
	int pass_count;

	icache_top i_dut (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_ready(rsp_ready),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	icache_apb_mem #(
		.DATA_KEY(DATA_KEY),
		.SEED(32'h08af0201)
	) i_mem (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle <= cycle + 1;
		if (cycle >= CYCLE_LIMIT) begin
			$display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
			$display("Test failed");
			$finish;
		end
	end

	task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp) begin
			$display("FAILED at time %0t: %s, got %h, expected %h", $time, what, got, exp);
			error_count++;
		end
	endtask

	task automatic load_table();
		// first miss, then hits in the same line
		tbl[0] = '{32'h0000_1000, 4'd0, 2'd0, 4'd4};
		tbl[1] = '{32'h0000_1004, 4'd0, 2'd0, 4'd0};
		tbl[2] = '{32'h0000_1008, 4'd0, 2'd0, 4'd0};
		tbl[3] = '{32'h0000_100c, 4'd0, 2'd0, 4'd0};
		// five lines on set 5, then refetches
		tbl[4] = '{32'h0000_4050, 4'd0, 2'd0, 4'd4};
		tbl[5] = '{32'h0000_4454, 4'd0, 2'd0, 4'd4};
		tbl[6] = '{32'h0000_4858, 4'd0, 2'd0, 4'd4};
		tbl[7] = '{32'h0000_4c5c, 4'd0, 2'd0, 4'd4};
		tbl[8] = '{32'h0000_5050, 4'd0, 2'd0, 4'd4};
		tbl[9] = '{32'h0000_4054, 4'd0, 2'd0, 4'd4};
		tbl[10] = '{32'h0000_4450, 4'd0, 2'd0, 4'd4};
		tbl[11] = '{32'h0000_4c50, 4'd0, 2'd0, 4'd0};
		// decode stalls on a hit and on a miss
		tbl[12] = '{32'h0000_1008, 4'd6, 2'd0, 4'd0};
		tbl[13] = '{32'h0000_2020, 4'd5, 2'd0, 4'd4};
		// flushed fetches and their lines afterwards
		tbl[14] = '{32'h0000_3040, 4'd0, 2'd1, 4'd0};
		tbl[15] = '{32'h0000_3044, 4'd0, 2'd0, 4'd4};
		tbl[16] = '{32'h0000_3460, 4'd0, 2'd2, 4'd4};
		tbl[17] = '{32'h0000_3468, 4'd0, 2'd0, 4'd0};
		tbl[18] = '{32'h0000_1004, 4'd0, 2'd0, 4'd0};
	endtask

	task automatic run_entry(input int idx);
		entry_t e;
		int errs_before;
		int xfers_before;
		int acc_cycle;
		int idle;
		int k;
		logic seen;
		logic [31:0] exp_word;
		logic [31:0] held;
		logic [31:0] line_base;
		e = tbl[idx];
		errs_before = error_count;
		xfers_before = i_mem.xfer_count;
		exp_word = {e.addr[31:2], 2'b00} ^ DATA_KEY;
		line_base = {e.addr[31:4], 4'h0};
		req_valid = 1'b1;
		req_addr.raw = e.addr;
		rsp_ready = (e.stall == 4'd0);
		seen = 1'b0;
		while (!seen) begin
			@(negedge clk);
			seen = req_ready;
			@(posedge clk);
			#1;
		end
		req_valid = 1'b0;
		acc_cycle = cycle;
		if (e.flush_mode == 2'd0) begin
			do begin
				@(negedge clk);
			end while (!rsp.valid);
			if (e.xfers == 4'd0) begin
				check_value("hit latency", cycle - acc_cycle, 1);
			end
			check_value("fetched word", rsp.inst, exp_word);
			held = rsp.inst;
			for (k = 0; k < e.stall; k++) begin
				@(posedge clk);
				#1;
				@(negedge clk);
				check_value("rsp valid under stall", rsp.valid, 1);
				check_value("rsp held under stall", rsp.inst, held);
				check_value("req_ready under stall", req_ready, 0);
			end
			@(posedge clk);
			#1;
			if (e.stall != 4'd0) begin
				rsp_ready = 1'b1;
				@(posedge clk);
				#1;
			end
			@(negedge clk);
			check_value("rsp retired", rsp.valid, 0);
		end else begin
			if (e.flush_mode == 2'd2) begin
				do begin
					@(negedge clk);
				end while (!psel);
				@(posedge clk);
				#1;
			end
			flush = 1'b1;
			@(posedge clk);
			#1;
			flush = 1'b0;
			// cache idle for a few cycles and still silent
			idle = 0;
			while (idle < 3) begin
				@(negedge clk);
				check_value("no rsp after flush", rsp.valid, 0);
				idle = (req_ready && !psel) ? idle + 1 : 0;
			end
		end
		@(posedge clk);
		#1;
		check_value("apb transfers", i_mem.xfer_count - xfers_before, e.xfers);
		if (e.xfers != 4'd0 && i_mem.xfer_count - xfers_before == e.xfers) begin
			for (k = 0; k < 4; k++) begin
				check_value("apb address", i_mem.addr_log[(xfers_before + k) % 256],
					line_base + 4 * k);
			end
		end
		if (error_count == errs_before) begin
			pass_count++;
			$display("test %0d addr %h: pass", idx, e.addr);
		end else begin
			$display("test %0d addr %h: %0d mismatches", idx, e.addr, error_count - errs_before);
		end
	endtask

	// two hits on a resident line, the second accepted while the first answers
	task automatic issue_back_to_back_hits();
		logic [31:0] addrs [2];
		int acc [2];
		int errs_before;
		int xfers_before;
		int n;
		logic seen;
		addrs[0] = 32'h0000_1000;
		addrs[1] = 32'h0000_100c;
		errs_before = error_count;
		xfers_before = i_mem.xfer_count;
		rsp_ready = 1'b1;
		req_valid = 1'b1;
		for (n = 0; n < 2; n++) begin
			req_addr.raw = addrs[n];
			seen = 1'b0;
			while (!seen) begin
				@(negedge clk);
				seen = req_ready;
				@(posedge clk);
				#1;
			end
			acc[n] = cycle;
		end
		req_valid = 1'b0;
		check_value("second fetch accepted next cycle", acc[1] - acc[0], 1);
		for (n = 0; n < 2; n++) begin
			do begin
				@(negedge clk);
			end while (!rsp.valid);
			check_value("back-to-back hit latency", cycle - acc[n], 1);
			check_value("back-to-back word", rsp.inst, addrs[n] ^ DATA_KEY);
		end
		@(posedge clk);
		#1;
		@(negedge clk);
		check_value("rsp retired", rsp.valid, 0);
		@(posedge clk);
		#1;
		check_value("apb transfers", i_mem.xfer_count - xfers_before, 0);
		if (error_count == errs_before) begin
			pass_count++;
			$display("back-to-back hits: pass");
		end else begin
			$display("back-to-back hits: %0d mismatches", error_count - errs_before);
		end
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		flush = 1'b0;
		req_valid = 1'b0;
		req_addr = '0;
		rsp_ready = 1'b1;
		error_count = 0;
		pass_count = 0;
		load_table();
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;
		@(negedge clk);
		check_value("rsp valid after reset", rsp.valid, 0);
		check_value("req_ready after reset", req_ready, 1);
		check_value("psel after reset", psel, 0);
		check_value("penable after reset", penable, 0);
		$display("reset state: %0d mismatches", error_count);
		@(posedge clk);
		#1;
		for (int i = 0; i < NUM_TESTS; i++) begin
			run_entry(i);
		end
		issue_back_to_back_hits();
		check_value("apb writes", i_mem.write_count, 0);
		$display("%0d tests, %0d passed, %0d mismatches", NUM_TESTS + 1, pass_count,
			error_count);
		if (error_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verification/icache_apb_mem.sv
`default_nettype none

module icache_apb_mem #(
	parameter logic [31:0] DATA_KEY = 32'h5eed_c0de,
	parameter logic [31:0] SEED = 32'h0000_0001
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        psel,
	input  logic        penable,
	input  logic [31:0] paddr,
	input  logic        pwrite,
	output logic [31:0] prdata,
	output logic        pready,
	output logic        pslverr
);

	logic [1:0] wait_left;
	int xfer_count;
	int write_count;
	// addresses of completed transfers, in order
	logic [31:0] addr_log [256];

	assign pready = psel && penable && (wait_left == 2'd0);
	assign prdata = paddr ^ DATA_KEY;
	assign pslverr = 1'b0;

	// wait states come from one seeded stream
	initial begin
		logic [31:0] seed_var;
		seed_var = SEED;
		void'($urandom(seed_var));
		wait_left = '0;
		xfer_count = 0;
		write_count = 0;
		forever begin
			@(posedge clk);
			if (rst) begin
				wait_left <= '0;
				xfer_count <= 0;
				write_count <= 0;
			end else if (psel && !penable) begin
				// setup cycle picks 0 to 3 wait states
				wait_left <= 2'($urandom % 4);
			end else if (psel && penable) begin
				if (wait_left != 2'd0) begin
					wait_left <= wait_left - 2'd1;
				end else begin
					addr_log[xfer_count % 256] <= paddr;
					xfer_count <= xfer_count + 1;
					if (pwrite) begin
						write_count <= write_count + 1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; #(
	parameter int ICACHE_WAYS = icache_pkg::ICACHE_WAYS,
	parameter int ICACHE_SETS = icache_pkg::ICACHE_SETS
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         flush,
	input  logic         req_valid,
	input  icache_addr_u req_addr,
	output logic         req_ready,
	output icache_rsp_t  rsp,
	input  logic         rsp_ready,
	output logic         psel,
	output logic         penable,
	output logic [31:0]  paddr,
	output logic         pwrite,
	input  logic [31:0]  prdata,
	input  logic         pready,
	input  logic         pslverr
);

	icache_lookup_t lookup;
	icache_line_t lines [ICACHE_WAYS];
	icache_fill_t fill;
	logic lookup_en;
	logic fill_en;

	icache_tag_store #(
		.ICACHE_WAYS(ICACHE_WAYS),
		.ICACHE_SETS(ICACHE_SETS)
	) i_tag_store (
		.clk(clk),
		.rst(rst),
		.lookup_en(lookup_en),
		.lookup_addr(req_addr),
		.fill(fill),
		.fill_en(fill_en),
		.lookup(lookup)
	);

	icache_data_store #(
		.ICACHE_WAYS(ICACHE_WAYS),
		.ICACHE_SETS(ICACHE_SETS)
	) i_data_store (
		.clk(clk),
		.rd_en(lookup_en),
		.rd_index(req_addr.f.index),
		.fill(fill),
		.fill_en(fill_en),
		.lines(lines)
	);

	icache_fetch_ctrl i_fetch_ctrl (
		.clk(clk),
		.rst(rst),
		.flush(flush),
		.req_valid(req_valid),
		.req_addr(req_addr),
		.req_ready(req_ready),
		.rsp(rsp),
		.rsp_ready(rsp_ready),
		.lookup(lookup),
		.lines(lines),
		.lookup_en(lookup_en),
		.fill(fill),
		.fill_en(fill_en),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

endmodule

`default_nettype wire

// File: hdl/icache_fetch_ctrl.sv
`default_nettype none

module icache_fetch_ctrl import icache_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  logic           flush,
	input  logic           req_valid,
	input  icache_addr_u   req_addr,
	output logic           req_ready,
	output icache_rsp_t    rsp,
	input  logic           rsp_ready,
	input  icache_lookup_t lookup,
	input  icache_line_t   lines [ICACHE_WAYS],
	output logic           lookup_en,
	output icache_fill_t   fill,
	output logic           fill_en,
	output logic           psel,
	output logic           penable,
	output logic [31:0]    paddr,
	output logic           pwrite,
	input  logic [31:0]    prdata,
	input  logic           pready,
	input  logic           pslverr
);

	localparam logic [1:0] CTRL_IDLE = 2'd0;
	localparam logic [1:0] CTRL_REFILL = 2'd1;
	localparam logic [1:0] CTRL_ANSWER = 2'd2;

	logic [1:0] state;
	logic stage_valid;
	logic miss_live;
	logic rsp_valid_q;
	logic [31:0] rsp_inst_q;
	logic rsp_free, hit_adv, miss_start, answer_now;
	logic refill_done;
	icache_line_t refill_line, hit_line;
	icache_addr_u refill_addr;

	assign rsp_free = !rsp_valid_q || rsp_ready;
	assign hit_adv = stage_valid && lookup.hit && rsp_free;
	assign miss_start = stage_valid && !lookup.hit && !flush;
	// the refill word waits here while decode holds the previous one
	assign answer_now = ((state == CTRL_REFILL && refill_done) || state == CTRL_ANSWER) &&
		rsp_free;
	assign req_ready = (state == CTRL_IDLE) && rsp_free && !(stage_valid && !lookup.hit);
	assign lookup_en = req_valid && req_ready;
	assign rsp = '{inst: rsp_inst_q, valid: rsp_valid_q};

	// line from the hit way
	always_comb begin
		hit_line = '0;
		for (int w = 0; w < ICACHE_WAYS; w++) begin
			if (lookup.hit_way[w]) begin
				hit_line = hit_line | lines[w];
			end
		end
	end

	always_comb begin
		refill_addr = '0;
		refill_addr.f.tag = lookup.tag;
		refill_addr.f.index = lookup.index;
	end

	assign fill = '{way: lookup.victim_way, index: lookup.index, tag: lookup.tag,
		line: refill_line};
	assign fill_en = refill_done;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= CTRL_IDLE;
			stage_valid <= 1'b0;
			miss_live <= 1'b0;
			rsp_valid_q <= 1'b0;
		end else begin
			if (lookup_en) begin
				stage_valid <= 1'b1;
			end else if (flush || (stage_valid && (!lookup.hit || rsp_free))) begin
				stage_valid <= 1'b0;
			end
			case (state)
				CTRL_IDLE: if (miss_start) state <= CTRL_REFILL;
				CTRL_REFILL: if (refill_done) state <= rsp_free ? CTRL_IDLE : CTRL_ANSWER;
				CTRL_ANSWER: if (rsp_free) state <= CTRL_IDLE;
				default: state <= CTRL_IDLE;
			endcase
			// a flushed miss still fills, but gives no answer
			if (miss_start) begin
				miss_live <= 1'b1;
			end else if (flush || answer_now) begin
				miss_live <= 1'b0;
			end
			if (flush) begin
				rsp_valid_q <= 1'b0;
			end else if (hit_adv) begin
				rsp_valid_q <= 1'b1;
			end else if (answer_now) begin
				rsp_valid_q <= miss_live;
			end else if (rsp_ready) begin
				rsp_valid_q <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (hit_adv) begin
			rsp_inst_q <= hit_line[lookup.word];
		end else if (answer_now) begin
			rsp_inst_q <= refill_line[lookup.word];
		end
	end

	icache_apb_refill i_refill (
		.clk(clk),
		.rst(rst),
		.start(miss_start),
		.line_addr(refill_addr),
		.done(refill_done),
		.line(refill_line),
		.psel(psel),
		.penable(penable),
		.paddr(paddr),
		.pwrite(pwrite),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

endmodule

`default_nettype wire

// File: hdl/icache_apb_refill.sv
`default_nettype none

module icache_apb_refill import icache_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         start,
	input  icache_addr_u line_addr,
	output logic         done,
	output icache_line_t line,
	output logic         psel,
	output logic         penable,
	output logic [31:0]  paddr,
	output logic         pwrite,
	input  logic [31:0]  prdata,
	input  logic         pready,
	input  logic         pslverr
);

	localparam int CNT_W = $clog2(WORDS_PER_LINE);

	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_SETUP = 2'd1;
	localparam logic [1:0] ST_ACCESS = 2'd2;

	logic [1:0] state;
	logic [CNT_W-1:0] word_cnt;
	logic [31-OFFSET_W:0] base;
	logic last_word;

	assign psel = (state != ST_IDLE);
	assign penable = (state == ST_ACCESS);
	assign pwrite = 1'b0;
	assign paddr = {base, word_cnt, 2'b00};
	assign last_word = (word_cnt == CNT_W'(WORDS_PER_LINE - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_IDLE;
			word_cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (start) begin
						word_cnt <= '0;
						state <= ST_SETUP;
					end
				end
				ST_SETUP: state <= ST_ACCESS;
				ST_ACCESS: begin
					if (pready) begin
						if (last_word) begin
							state <= ST_IDLE;
							done <= 1'b1;
						end else begin
							word_cnt <= word_cnt + 1'b1;
							state <= ST_SETUP;
						end
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// line base and collected words
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			base <= line_addr.raw[31:OFFSET_W];
		end
		if (state == ST_ACCESS && pready) begin
			line[word_cnt] <= prdata;
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_data_store.sv
`default_nettype none

module icache_data_store import icache_pkg::*; #(
	parameter int ICACHE_WAYS = icache_pkg::ICACHE_WAYS,
	parameter int ICACHE_SETS = icache_pkg::ICACHE_SETS
) (
	input  logic               clk,
	input  logic               rd_en,
	input  logic [INDEX_W-1:0] rd_index,
	input  icache_fill_t       fill,
	input  logic               fill_en,
	output icache_line_t       lines [ICACHE_WAYS]
);

	// one line array per way
	for (genvar w = 0; w < ICACHE_WAYS; w++) begin : g_way
		icache_line_t mem [ICACHE_SETS];

		always_ff @(posedge clk) begin
			if (fill_en && fill.way[w]) begin
				mem[fill.index] <= fill.line;
			end
		end

		// all ways read together, the controller picks one later
		always_ff @(posedge clk) begin
			if (rd_en) begin
				lines[w] <= mem[rd_index];
			end
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_tag_store.sv
`default_nettype none

module icache_tag_store import icache_pkg::*; #(
	parameter int ICACHE_WAYS = icache_pkg::ICACHE_WAYS,
	parameter int ICACHE_SETS = icache_pkg::ICACHE_SETS
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           lookup_en,
	input  icache_addr_u   lookup_addr,
	input  icache_fill_t   fill,
	input  logic           fill_en,
	output icache_lookup_t lookup
);

	logic [TAG_W-1:0] tags [ICACHE_WAYS][ICACHE_SETS];
	logic [ICACHE_SETS-1:0] valid_bits [ICACHE_WAYS];
	logic [ICACHE_WAYS-1:0] victim;
	logic [ICACHE_WAYS-1:0] hit_vec;

	// all ways compared in parallel against the incoming address
	always_comb begin
		for (int w = 0; w < ICACHE_WAYS; w++) begin
			hit_vec[w] = valid_bits[w][lookup_addr.f.index] &&
				(tags[w][lookup_addr.f.index] == lookup_addr.f.tag);
		end
	end

	// lookup result, held until the next accepted fetch
	always_ff @(posedge clk) begin
		if (lookup_en) begin
			lookup.hit <= |hit_vec;
			lookup.hit_way <= hit_vec;
			lookup.victim_way <= victim;
			lookup.index <= lookup_addr.f.index;
			lookup.word <= lookup_addr.f.word;
			lookup.tag <= lookup_addr.f.tag;
		end
	end

	always_ff @(posedge clk) begin
		if (fill_en) begin
			for (int w = 0; w < ICACHE_WAYS; w++) begin
				if (fill.way[w]) begin
					tags[w][fill.index] <= fill.tag;
				end
			end
		end
	end

	// valid bits and the rotating victim pointer
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int w = 0; w < ICACHE_WAYS; w++) begin
				valid_bits[w] <= '0;
			end
			victim <= ICACHE_WAYS'(1);
		end else if (fill_en) begin
			for (int w = 0; w < ICACHE_WAYS; w++) begin
				if (fill.way[w]) begin
					valid_bits[w][fill.index] <= 1'b1;
				end
			end
			// one step per refill
			victim <= {victim[ICACHE_WAYS-2:0], victim[ICACHE_WAYS-1]};
		end
	end

endmodule

`default_nettype wire

// File: hdl/icache_pkg.sv
`default_nettype none

package icache_pkg;

	// cache geometry, top level takes these as parameter defaults
	localparam int ICACHE_WAYS = 4;
	localparam int ICACHE_SETS = 64;

	localparam int INDEX_W = 6;
	localparam int OFFSET_W = 4;
	localparam int TAG_W = 22;
	localparam int WORDS_PER_LINE = 4;

	// fetch address split into cache fields
	typedef struct packed {
		logic [TAG_W-1:0]   tag;
		logic [INDEX_W-1:0] index;
		logic [1:0]         word;
		logic [1:0]         byte_ofs;
	} icache_addr_fields_t;

	typedef union packed {
		logic [31:0]         raw;
		icache_addr_fields_t f;
	} icache_addr_u;

	// word 0 sits in the low bits, as it comes from the line base
	typedef logic [WORDS_PER_LINE-1:0][31:0] icache_line_t;

	typedef struct packed {
		logic                   hit;
		logic [ICACHE_WAYS-1:0] hit_way;
		logic [ICACHE_WAYS-1:0] victim_way;
		logic [INDEX_W-1:0]     index;
		logic [1:0]             word;
		logic [TAG_W-1:0]       tag;
	} icache_lookup_t;

	typedef struct packed {
		logic [31:0] inst;
		logic        valid;
	} icache_rsp_t;

	typedef struct packed {
		logic [ICACHE_WAYS-1:0] way;
		logic [INDEX_W-1:0]     index;
		logic [TAG_W-1:0]       tag;
		icache_line_t           line;
	} icache_fill_t;

endpackage

`default_nettype wire
